//--- build.f
logic/pi1_pkg.sv
logic/rst_seq.sv
logic/pi1_decoder.sv
logic/pi1_ram_dev.sv
logic/pi1_resp_mux.sv
logic/devtbl.sv
logic/pi1_soc_top.sv
dv/pi1_soc_tb.sv

//--- dv/pi1_soc_tb.sv
// pi1 memory subsystem testbench
// table-driven bus transfers checked against a shadow model, plus warm reset and power-off

module pi1_soc_tb
	import pi1_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NDEV       = 3;
	localparam int DEV_WORDS  = 64;
	localparam int RST_CYCLES = 16;
	localparam int RST_HOLD   = 16;
	localparam int INVAL_ADDR = 32'h3fff_ffff; // top slot index, far past the RAM devices

	typedef struct packed {
		pi1_op_e           op;
		logic [ADDR_W-1:0] addr;
		logic [ARCH_W-1:0] data;
		logic [SEL_W-1:0]  sel;
		logic              cmd; // control write, followed by a reset check
	} stim_t;

	logic              clk120mhz = 1'b0;
	logic              rst_p;
	pi1_req_t          req;
	pi1_rsp_t          rsp;
	logic              sys_rst;
	logic              halted;
	stim_t             tbl [$];
	logic [ARCH_W-1:0] shadow [NDEV][DEV_WORDS]; // RAM device contents
	logic [31:0]       lfsr = 32'd32778;
	bit                tbl_done;
	int                n_checks;
	int                n_errs;
	int                n_fails; // missing rdy

	pi1_soc_top #(.NDEV(NDEV), .DEV_WORDS(DEV_WORDS), .RST_CYCLES(RST_CYCLES)) u_dut (
		.clk120mhz (clk120mhz),
		.rst_p     (rst_p),
		.req_i     (req),
		.rsp_o     (rsp),
		.sys_rst_o (sys_rst),
		.halted_o  (halted)
	);

	always #4 clk120mhz = ~clk120mhz;

	// galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r    = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
		end
		return r;
	endfunction

	// writes and swaps carry a random word, part_sel adds random byte selects
	function automatic void add_stim(input pi1_op_e kind, input int addr, input bit part_sel,
			input logic [ARCH_W-1:0] cmd_data = '0, input bit cmd = 1'b0);
		stim_t s;
		s.op   = kind;
		s.addr = ADDR_W'(addr);
		s.data = cmd_data;
		s.sel  = '1;
		s.cmd  = cmd;
		if (kind != PI1_READ && !cmd) begin
			s.data = rand_bits(ARCH_W);
			s.sel  = part_sel ? SEL_W'(rand_bits(SEL_W)) : s.sel;
		end
		tbl.push_back(s);
	endfunction

	function automatic void build_table();
		for (int k = 1; k <= NDEV; k++) begin
			add_stim(PI1_WRITE, (k << SLOT_AW) + 3, 1'b0);
			add_stim(PI1_WRITE, (k << SLOT_AW) + 17, 1'b0);
			add_stim(PI1_WRITE, (k << SLOT_AW) + 3, 1'b1);
			add_stim(PI1_READ, (k << SLOT_AW) + 3, 1'b0);
			add_stim(PI1_READ, (k << SLOT_AW) + 17 + DEV_WORDS, 1'b0); // aliases offset 17
		end
		add_stim(PI1_RDWR, (2 << SLOT_AW) + 17, 1'b1);
		add_stim(PI1_READ, (2 << SLOT_AW) + 17, 1'b0);
		for (int n = 0; n <= 5; n++) begin
			add_stim(PI1_READ, n, 1'b0); // map sizes
		end
		////////////////////
		// invalid slots, then warm reset and power-off
		add_stim(PI1_WRITE, ((NDEV + 1) << SLOT_AW) + 3, 1'b0);
		add_stim(PI1_RDWR, (5 << SLOT_AW) + 17, 1'b0);
		add_stim(PI1_READ, INVAL_ADDR, 1'b0);
		add_stim(PI1_WRITE, 0, 1'b0, ARCH_W'(RST_WARM), 1'b1);
		for (int k = 1; k <= NDEV; k++) begin
			add_stim(PI1_READ, (k << SLOT_AW) + 3, 1'b0);
			add_stim(PI1_READ, (k << SLOT_AW) + 17, 1'b0);
		end
		add_stim(PI1_WRITE, 0, 1'b0, ARCH_W'(RST_PWROFF), 1'b1);
		add_stim(PI1_RDWR, (3 << SLOT_AW) + 3, 1'b0);
		add_stim(PI1_READ, (3 << SLOT_AW) + 3, 1'b0);
		add_stim(PI1_READ, 2, 1'b0);
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errs++;
			$display("** Error %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic do_xfer(input stim_t s);
		logic [ARCH_W-1:0] exp_data;
		int                slot;
		int                off;
		int                lat;
		slot = int'(s.addr >> SLOT_AW);
		off  = int'(s.addr[SLOT_AW-1:0]);
		lat  = 0;
		if (slot == 0) begin
			exp_data = (off == 0) ? (1 << SLOT_AW) : (off <= NDEV) ? DEV_WORDS : 0;
		end else begin
			exp_data = (slot <= NDEV) ? shadow[slot-1][off % DEV_WORDS] : '0;
		end
		req = '{op: s.op, addr: s.addr, data: s.data, sel: s.sel};
		#2;
		while (!rsp.rdy && lat < 8) begin
			@(negedge clk120mhz);
			#2;
			lat++;
		end
		if (!rsp.rdy) begin
			n_fails++;
			$display("no rdy within 8 cycles for op %0d at address 0x%08h", s.op, s.addr);
		end else begin
			check_val("rdy latency", lat, (slot > NDEV) ? 0 : 1);
			if (s.op == PI1_READ || s.op == PI1_RDWR) begin
				check_val("rsp_o.data", rsp.data, exp_data);
			end
			for (int b = 0; b < SEL_W; b++) begin
				if (s.op != PI1_READ && slot >= 1 && slot <= NDEV && s.sel[b]) begin
					shadow[slot-1][off % DEV_WORDS][b*8 +: 8] = s.data[b*8 +: 8];
				end
			end
		end
		@(negedge clk120mhz); // request held through the rdy cycle
	endtask

	task automatic apply_reset();
		int n;
		n     = 0;
		rst_p = 1'b1;
		repeat (RST_HOLD) @(negedge clk120mhz);
		rst_p = 1'b0;
		while (sys_rst !== 1'b0 && n < 3 * RST_CYCLES) begin
			@(negedge clk120mhz);
			n++;
		end
		#2;
		check_val("sys_rst_o cycles", n, RST_CYCLES);
		check_val("halted_o", halted, 1'b0);
		check_val("rsp_o.rdy", rsp.rdy, 1'b0);
		@(negedge clk120mhz);
	endtask

	// a held invalid read must stay unanswered while the system is in reset
	task automatic reset_check(input bit pwroff);
		int n;
		n   = 0;
		req = '{op: PI1_READ, addr: ADDR_W'(INVAL_ADDR), data: '0, sel: '0};
		#2;
		while (sys_rst && n < 3 * RST_CYCLES) begin
			check_val("rsp_o.rdy", rsp.rdy, 1'b0);
			check_val("halted_o", halted, pwroff);
			n++;
			@(negedge clk120mhz);
			#2;
		end
		check_val("sys_rst_o cycles", n, pwroff ? 3 * RST_CYCLES : RST_CYCLES);
		@(negedge clk120mhz);
		req.op = PI1_NOP;
		if (pwroff) begin
			apply_reset(); // only rst_p leaves power-off
		end
	endtask

	initial begin
		rst_p = 1'b1;
		req   = '0;
		build_table();
		tbl_done = 1'b1;
		apply_reset();
		foreach (tbl[i]) begin
			do_xfer(tbl[i]);
			if (tbl[i].cmd) begin
				reset_check(tbl[i].data[1:0] == RST_PWROFF);
			end
			req.op = PI1_NOP;
			@(negedge clk120mhz);
		end
		$display("%0d checks, %0d value errors, %0d missing rdy",
			n_checks, n_errs, n_fails);
		if (n_errs == 0 && n_fails == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	////////////////////
	// watchdog
	initial begin
		int limit;
		wait (tbl_done);
		limit = tbl.size() * 40 + 2 * (RST_HOLD + RST_CYCLES) + 4 * RST_CYCLES;
		repeat (limit) @(posedge clk120mhz);
		$display("watchdog expired after %0d cycles before the table was done", limit);
		$display("Some tests failed");
		$finish;
	end

endmodule

//--- logic/devtbl.sv
// device table
// reports each slot's map size and turns control-word writes into reset commands

module devtbl
	import pi1_pkg::*;
#(
	parameter int NDEV      = 3,
	parameter int DEV_WORDS = 64
) (
	input  logic     clk120mhz,
	input  logic     sys_rst_i,
	input  pi1_req_t req_i,
	output pi1_rsp_t rsp_o,
	output rst_cmd_e rst_cmd_o
);

	localparam logic [ARCH_W-1:0] TBL_WORDS = ARCH_W'(1 << SLOT_AW);

	logic [ARCH_W-1:0] rd_data;
	logic [ARCH_W-1:0] mapsz;
	logic              rdy_q;
	logic              req_new;
	logic              ctl_wr; // write to the control word at offset 0
	rst_cmd_e          cmd_dec;
	rst_cmd_e          cmd_q;

	assign req_new = (req_i.op != PI1_NOP) && !rdy_q;
	assign ctl_wr  = req_new && (req_i.addr == '0) &&
		(req_i.op == PI1_WRITE || req_i.op == PI1_RDWR);

	always_comb begin
		if (req_i.addr == '0) begin
			mapsz = TBL_WORDS; // the table itself
		end else if (req_i.addr <= ADDR_W'(NDEV)) begin
			mapsz = ARCH_W'(DEV_WORDS);
		end else begin
			mapsz = '0;
		end
	end

	always_comb begin
		case (req_i.data[1:0])
			RST_WARM:   cmd_dec = RST_WARM;
			RST_PWROFF: cmd_dec = RST_PWROFF;
			default:    cmd_dec = RST_NONE; // code 3 is ignored
		endcase
	end

	always_ff @(posedge clk120mhz) begin
		if (sys_rst_i) begin
			rdy_q <= 1'b0;
			cmd_q <= RST_NONE;
		end else begin
			rdy_q <= req_new;
			cmd_q <= ctl_wr ? cmd_dec : RST_NONE; // one-cycle pulse in the rdy cycle
		end
	end

	always_ff @(posedge clk120mhz) begin
		if (req_new) begin
			rd_data <= mapsz;
		end
	end

	assign rsp_o.data = rd_data;
	assign rsp_o.rdy  = rdy_q;
	assign rst_cmd_o  = cmd_q;

endmodule

//--- logic/pi1_decoder.sv
// pi1 address decoder
// routes the master request to one slot and flags unmapped addresses

module pi1_decoder
	import pi1_pkg::*;
#(
	parameter int NDEV = 3
) (
	input  logic          clk120mhz,
	input  logic          sys_rst_i,
	input  pi1_req_t      req_i,
	output pi1_req_t      slot_req_o [NDEV+1],
	output logic [NDEV:0] slot_sel_o,
	output logic          inval_o
);

	localparam int IDX_W = ADDR_W - SLOT_AW;

	logic [IDX_W-1:0] slot_idx;
	logic             req_act;
	logic             inval_hit;
	logic             inval_q; // invalid answer given last cycle
	pi1_req_t         req_q;

	assign slot_idx  = req_i.addr[ADDR_W-1:SLOT_AW];
	assign req_act   = !sys_rst_i && (req_i.op != PI1_NOP);
	assign inval_hit = req_act && (slot_idx > IDX_W'(NDEV));

	always_comb begin
		for (int s = 0; s <= NDEV; s++) begin
			slot_sel_o[s]      = req_act && (slot_idx == IDX_W'(s));
			slot_req_o[s]      = req_i;
			slot_req_o[s].addr = {{IDX_W{1'b0}}, req_i.addr[SLOT_AW-1:0]}; // in-slot offset
			if (!slot_sel_o[s]) begin
				slot_req_o[s].op = PI1_NOP;
			end
		end
	end

	////////////////////
	// invalid device

	// a request still held after its answer is not answered twice
	assign inval_o = inval_hit && !(inval_q && (req_i == req_q));

	always_ff @(posedge clk120mhz) begin
		if (sys_rst_i) begin
			inval_q <= 1'b0;
		end else begin
			inval_q <= inval_o;
		end
	end

	always_ff @(posedge clk120mhz) begin
		req_q <= req_i;
	end

endmodule

//--- logic/pi1_pkg.sv
// pi1 bus definitions
// opcodes, reset commands and the request and response records of the memory subsystem

package pi1_pkg;

	////////////////////
	// widths

	localparam int ARCH_W  = 32; // data bits
	localparam int ADDR_W  = 30; // word address
	localparam int SEL_W   = ARCH_W / 8; // one select per byte
	localparam int SLOT_AW = 10; // 1024 words per slot

	////////////////////
	// encodings

	typedef enum logic [1:0] {
		PI1_NOP   = 2'd0,
		PI1_WRITE = 2'd1,
		PI1_READ  = 2'd2,
		PI1_RDWR  = 2'd3 // swap, old word comes back
	} pi1_op_e;

	typedef enum logic [1:0] {
		RST_NONE   = 2'd0,
		RST_WARM   = 2'd1,
		RST_PWROFF = 2'd2
	} rst_cmd_e;

	////////////////////
	// bus records

	typedef struct packed {
		pi1_op_e             op;
		logic [ADDR_W-1:0] addr;
		logic [ARCH_W-1:0] data;
		logic [SEL_W-1:0]  sel;
	} pi1_req_t;

	typedef struct packed {
		logic [ARCH_W-1:0] data;
		logic              rdy;
	} pi1_rsp_t;

endpackage

//--- logic/pi1_ram_dev.sv
// pi1 word RAM device
// byte-selectable read, write and swap with a one-cycle answer

module pi1_ram_dev
	import pi1_pkg::*;
#(
	parameter int DEV_WORDS = 64
) (
	input  logic     clk120mhz,
	input  logic     sys_rst_i,
	input  pi1_req_t req_i,
	output pi1_rsp_t rsp_o
);

	localparam int IDX_W = $clog2(DEV_WORDS);

	logic [ARCH_W-1:0] mem [DEV_WORDS];
	logic [ARCH_W-1:0] rd_data;
	logic [IDX_W-1:0]  idx;
	logic              rdy_q;
	logic              req_new;
	logic              wr_en;

	assign idx     = req_i.addr[IDX_W-1:0]; // aliases within the slot
	assign req_new = (req_i.op != PI1_NOP) && !rdy_q;
	assign wr_en   = rdy_q && (req_i.op == PI1_WRITE || req_i.op == PI1_RDWR);

	always_ff @(posedge clk120mhz) begin
		if (sys_rst_i) begin
			rdy_q <= 1'b0;
		end else begin
			rdy_q <= req_new;
		end
	end

	// the old word is taken on the request cycle, the write lands in the rdy cycle
	always_ff @(posedge clk120mhz) begin
		if (req_new) begin
			rd_data <= mem[idx];
		end
	end

	always_ff @(posedge clk120mhz) begin
		if (wr_en) begin
			for (int b = 0; b < SEL_W; b++) begin
				if (req_i.sel[b]) begin
					mem[idx][b*8 +: 8] <= req_i.data[b*8 +: 8];
				end
			end
		end
	end

	assign rsp_o.data = rd_data;
	assign rsp_o.rdy  = rdy_q;

endmodule

//--- logic/pi1_resp_mux.sv
// pi1 response multiplexer
// returns data and rdy of the addressed slot, or the invalid-device answer

module pi1_resp_mux
	import pi1_pkg::*;
#(
	parameter int NDEV = 3
) (
	input  logic [NDEV:0] slot_sel_i,
	input  logic          inval_i,
	input  pi1_rsp_t      slot_rsp_i [NDEV+1],
	output pi1_rsp_t      rsp_o
);

	pi1_rsp_t sel_rsp;

	// one-hot select, so an AND-OR is enough
	always_comb begin
		sel_rsp = '0;
		for (int s = 0; s <= NDEV; s++) begin
			sel_rsp.data = sel_rsp.data | (slot_rsp_i[s].data & {ARCH_W{slot_sel_i[s]}});
			sel_rsp.rdy  = sel_rsp.rdy | (slot_rsp_i[s].rdy & slot_sel_i[s]);
		end
	end

	always_comb begin
		if (inval_i) begin
			rsp_o.data = '0; // invalid device reads zero
			rsp_o.rdy  = 1'b1;
		end else begin
			rsp_o = sel_rsp;
		end
	end

endmodule

//--- logic/pi1_soc_top.sv
// pi1 memory subsystem top
// reset sequencer, decoder, device table, RAM devices and response multiplexer

module pi1_soc_top
	import pi1_pkg::*;
#(
	parameter int NDEV       = 3,
	parameter int DEV_WORDS  = 64,
	parameter int RST_CYCLES = 16
) (
	input  logic     clk120mhz,
	input  logic     rst_p,
	input  pi1_req_t req_i,
	output pi1_rsp_t rsp_o,
	output logic     sys_rst_o,
	output logic     halted_o
);

	rst_cmd_e      rst_cmd;
	pi1_req_t      slot_req [NDEV+1];
	pi1_rsp_t      slot_rsp [NDEV+1];
	logic [NDEV:0] slot_sel;
	logic          inval;

	rst_seq #(
		.RST_CYCLES (RST_CYCLES)
	) u_rst_seq (
		.clk120mhz (clk120mhz),
		.rst_p     (rst_p),
		.rst_cmd_i (rst_cmd),
		.sys_rst_o (sys_rst_o),
		.halted_o  (halted_o)
	);

	pi1_decoder #(
		.NDEV (NDEV)
	) u_decoder (
		.clk120mhz  (clk120mhz),
		.sys_rst_i  (sys_rst_o),
		.req_i      (req_i),
		.slot_req_o (slot_req),
		.slot_sel_o (slot_sel),
		.inval_o    (inval)
	);

	////////////////////
	// slot 0 is the table, RAM k sits in slot k+1

	devtbl #(
		.NDEV      (NDEV),
		.DEV_WORDS (DEV_WORDS)
	) u_devtbl (
		.clk120mhz (clk120mhz),
		.sys_rst_i (sys_rst_o),
		.req_i     (slot_req[0]),
		.rsp_o     (slot_rsp[0]),
		.rst_cmd_o (rst_cmd)
	);

	for (genvar k = 0; k < NDEV; k++) begin : g_ram
		pi1_ram_dev #(
			.DEV_WORDS (DEV_WORDS)
		) u_ram (
			.clk120mhz (clk120mhz),
			.sys_rst_i (sys_rst_o),
			.req_i     (slot_req[k+1]),
			.rsp_o     (slot_rsp[k+1])
		);
	end

	pi1_resp_mux #(
		.NDEV (NDEV)
	) u_resp_mux (
		.slot_sel_i (slot_sel),
		.inval_i    (inval),
		.slot_rsp_i (slot_rsp),
		.rsp_o      (rsp_o)
	);

endmodule

//--- logic/rst_seq.sv
// reset sequencer
// stretches external and warm resets to RST_CYCLES and latches power-off

module rst_seq
	import pi1_pkg::*;
#(
	parameter int RST_CYCLES = 16
) (
	input  logic     clk120mhz,
	input  logic     rst_p,
	input  rst_cmd_e rst_cmd_i,
	output logic     sys_rst_o,
	output logic     halted_o
);

	localparam int CNT_W = $clog2(RST_CYCLES + 1);

	logic [CNT_W-1:0] rst_cnt;
	logic             pwroff_q;

	always_ff @(posedge clk120mhz) begin
		if (rst_p || rst_cmd_i == RST_WARM) begin
			rst_cnt <= CNT_W'(RST_CYCLES); // reload, warm reset restarts the count
		end else if (rst_cnt != '0) begin
			rst_cnt <= rst_cnt - 1'b1;
		end
	end

	// only the external reset brings the system back from power-off
	always_ff @(posedge clk120mhz) begin
		if (rst_p) begin
			pwroff_q <= 1'b0;
		end else if (rst_cmd_i == RST_PWROFF) begin
			pwroff_q <= 1'b1;
		end
	end

	assign sys_rst_o = (rst_cnt != '0) || pwroff_q;
	assign halted_o  = pwroff_q;

endmodule
